// File: list.f
+incdir+logic
logic/dly_pkg.sv
logic/dly_ctrl_if.sv
logic/dly_cmd_decode.sv
logic/dly_tap_engine.sv
logic/dly_readback.sv
logic/dly_bank_top.sv
test/tb_dly_bank.sv

// File: logic/dly_bank_top.sv
// Top level of the four-line tap delay bank.
// Plain ports in, the command decoder, tap engine and readback chained
// behind them through the control interface.

`timescale 1ns/1ns

`include "dly_consts.svh"

module dly_bank_top (
    input  logic                          clk_i_buf,
    input  logic                          reset_buf,
    input  dly_pkg::line_sel_t            sel_dly,
    input  logic [`DLY_NUM_LINES/2-1:0]   din_idly,
    input  logic [`DLY_NUM_LINES/2-1:0]   din_odly,
    input  dly_pkg::tap_t                 g2f_trx_dly_tap,
    input  logic                          dly_ld,
    input  logic                          dly_adj,
    input  logic                          dly_incdec,
    output dly_pkg::line_mask_t           data_delayed,  // bit 2i idly, 2i+1 odly
    output dly_pkg::tap_t                 dly_tap_val
);

    dly_pkg::line_mask_t din_mix;   // input and output side bits interleaved
    dly_pkg::tap_bus_t   tap_bus;

    dly_ctrl_if ctrl ();

    //****************************************
    // data interleave
    //****************************************
    for (genvar i = 0; i < `DLY_NUM_LINES/2; i++) begin : g_mix
        assign din_mix[2*i]   = din_idly[i];
        assign din_mix[2*i+1] = din_odly[i];
    end

    //****************************************
    // stages
    //****************************************
    dly_cmd_decode u_decode (
        .clk_i_buf (clk_i_buf),
        .reset_buf (reset_buf),
        .sel_dly   (sel_dly),
        .tap_load  (g2f_trx_dly_tap),
        .ld        (dly_ld),
        .adj       (dly_adj),
        .incdec    (dly_incdec),
        .ctrl      (ctrl.decode)
    );

    dly_tap_engine u_engine (
        .clk_i_buf (clk_i_buf),
        .reset_buf (reset_buf),
        .ctrl      (ctrl.execute),
        .din       (din_mix),
        .dout      (data_delayed),
        .taps      (tap_bus)
    );

    // shared tap readback
    dly_readback u_readback (
        .clk_i_buf (clk_i_buf),
        .reset_buf (reset_buf),
        .ctrl      (ctrl.result),
        .taps      (tap_bus),
        .tap_val   (dly_tap_val)
    );

endmodule

// File: logic/dly_cmd_decode.sv
// Decode stage of the delay bank.
// Registers select and command levels and expands them into one-cycle
// per-line strobes for the tap engine.

`timescale 1ns/1ns

module dly_cmd_decode (
    input  logic                clk_i_buf,
    input  logic                reset_buf,
    input  dly_pkg::line_sel_t  sel_dly,
    input  dly_pkg::tap_t       tap_load,
    input  logic                ld,
    input  logic                adj,
    input  logic                incdec,
    dly_ctrl_if.decode          ctrl
);

    dly_pkg::line_mask_t line_hot;   // selected line as a mask

    assign line_hot = dly_pkg::line_mask_t'(1) << sel_dly;

    //****************************************
    // command register
    //****************************************
    always_ff @(posedge clk_i_buf) begin
        if (!reset_buf) begin
            ctrl.line_sel <= '0;
            ctrl.ld_mask  <= '0;
            ctrl.adj_mask <= '0;
            ctrl.step_up  <= 1'b0;
        end else begin
            ctrl.line_sel <= sel_dly;
            ctrl.step_up  <= incdec;
            // load wins over adjust
            if (ld) begin
                ctrl.ld_mask  <= line_hot;
                ctrl.adj_mask <= '0;
            end else if (adj) begin
                ctrl.ld_mask  <= '0;
                ctrl.adj_mask <= line_hot;
            end else begin
                ctrl.ld_mask  <= '0;
                ctrl.adj_mask <= '0;
            end
        end
    end

    // load value for the next load strobe
    always_ff @(posedge clk_i_buf) begin
        ctrl.tap_in <= tap_load;
    end

    // at most one line is touched per cycle, and never by load and adjust at once
    a_strobe_excl: assert property (
        @(posedge clk_i_buf) disable iff (!reset_buf)
        $onehot0(ctrl.ld_mask) && $onehot0(ctrl.adj_mask) &&
        !((|ctrl.ld_mask) && (|ctrl.adj_mask))
    );

endmodule

// File: logic/dly_consts.svh
// Sizing constants for the tap delay bank.
// Included by the package and by any RTL file that sizes logic from them.

`ifndef DLY_CONSTS_SVH
`define DLY_CONSTS_SVH

// number of delay lines, even = input side, odd = output side
`define DLY_NUM_LINES   4

`define DLY_TAP_WIDTH   6   // bits per tap count
`define DLY_SEL_WIDTH   2   // bits of line select

// tap limits, counters saturate here
`define DLY_TAP_MAX     63

`define DLY_HIST_DEPTH  64  // stored samples per line

`endif

// File: logic/dly_ctrl_if.sv
// Registered command bundle from the decode stage.
// The tap engine takes the strobes, the readback takes the select.

`timescale 1ns/1ns

`include "dly_consts.svh"

interface dly_ctrl_if;

    logic [`DLY_SEL_WIDTH-1:0] line_sel;    // registered select
    logic [`DLY_NUM_LINES-1:0] ld_mask;     // one-hot or zero
    logic [`DLY_NUM_LINES-1:0] adj_mask;    // one-hot or zero
    logic                      step_up;     // 1 = increment
    logic [`DLY_TAP_WIDTH-1:0] tap_in;      // registered load value

    modport decode (output line_sel, ld_mask, adj_mask, step_up, tap_in);

    modport execute (input ld_mask, adj_mask, step_up, tap_in);

    modport result (input line_sel);

endinterface

// File: logic/dly_pkg.sv
// Shared types for the tap delay bank.
// Referenced by scoped name from the RTL modules.

package dly_pkg;

`include "dly_consts.svh"

    // one tap count
    typedef logic [`DLY_TAP_WIDTH-1:0] tap_t;

    // line number, also the command select
    typedef logic [`DLY_SEL_WIDTH-1:0] line_sel_t;

    // one bit per line
    typedef logic [`DLY_NUM_LINES-1:0] line_mask_t;

    // every line's tap count, line 0 in the low bits
    typedef tap_t [`DLY_NUM_LINES-1:0] tap_bus_t;

endpackage

// File: logic/dly_readback.sv
// Result stage of the delay bank.
// Registers the tap count of the line named by the registered select,
// giving the shared tap readback output.

`timescale 1ns/1ns

module dly_readback (
    input  logic               clk_i_buf,
    input  logic               reset_buf,
    dly_ctrl_if.result         ctrl,
    input  dly_pkg::tap_bus_t  taps,
    output dly_pkg::tap_t      tap_val
);

    dly_pkg::tap_t tap_pick;   // selected tap before the register

    assign tap_pick = taps[ctrl.line_sel];

    always_ff @(posedge clk_i_buf) begin
        if (!reset_buf) begin
            tap_val <= '0;
        end else begin
            tap_val <= tap_pick;   // one cycle behind the select
        end
    end

endmodule

// File: logic/dly_tap_engine.sv
// Execute stage of the delay bank.
// Holds one saturating tap counter per line and a sample history per line.
// Each line's output is the history bit at its current tap position, so a
// bit reaches dout tap+1 cycles after it is sampled.

`timescale 1ns/1ns

`include "dly_consts.svh"

module dly_tap_engine (
    input  logic                 clk_i_buf,
    input  logic                 reset_buf,
    dly_ctrl_if.execute          ctrl,
    input  dly_pkg::line_mask_t  din,      // interleaved, bit 2i idly, 2i+1 odly
    output dly_pkg::line_mask_t  dout,
    output dly_pkg::tap_bus_t    taps
);

    localparam dly_pkg::tap_t TAP_TOP = dly_pkg::tap_t'(`DLY_TAP_MAX);

    // newest sample in bit 0
    logic [`DLY_HIST_DEPTH-1:0] hist [`DLY_NUM_LINES];

    //****************************************
    // tap counters
    //****************************************
    always_ff @(posedge clk_i_buf) begin
        if (!reset_buf) begin
            taps <= '0;
        end else begin
            for (int i = 0; i < `DLY_NUM_LINES; i++) begin
                if (ctrl.ld_mask[i]) begin
                    taps[i] <= ctrl.tap_in;
                end else if (ctrl.adj_mask[i]) begin
                    if (ctrl.step_up) begin
                        if (taps[i] != TAP_TOP)
                            taps[i] <= taps[i] + 1'b1;   // hold at top
                    end else begin
                        if (taps[i] != '0)
                            taps[i] <= taps[i] - 1'b1;   // hold at zero
                    end
                end
            end
        end
    end

    //****************************************
    // sample history and tap select
    //****************************************
    always_ff @(posedge clk_i_buf) begin
        if (!reset_buf) begin
            for (int i = 0; i < `DLY_NUM_LINES; i++) begin
                hist[i] <= '0;
            end
            dout <= '0;
        end else begin
            for (int i = 0; i < `DLY_NUM_LINES; i++) begin
                hist[i] <= {hist[i][`DLY_HIST_DEPTH-2:0], din[i]};
                // hist[i][t] holds the bit sampled t cycles back
                dout[i] <= hist[i][taps[i]];
            end
        end
    end

    // adjust saturates, never wraps
    for (genvar g = 0; g < `DLY_NUM_LINES; g++) begin : g_sat_chk
        a_no_wrap_up: assert property (
            @(posedge clk_i_buf) disable iff (!reset_buf)
            (ctrl.adj_mask[g] && ctrl.step_up && taps[g] == TAP_TOP)
                |=> taps[g] == TAP_TOP
        );

        a_no_wrap_dn: assert property (
            @(posedge clk_i_buf) disable iff (!reset_buf)
            (ctrl.adj_mask[g] && !ctrl.step_up && taps[g] == '0)
                |=> taps[g] == '0
        );
    end

endmodule

// File: run.sh
#!/usr/bin/env bash
# Builds the tap delay bank testbench with Verilator and runs it.
# Exit status is nonzero when the run reports failure.
set -e

cd "$(dirname "$0")"

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f list.f \
    --top-module tb_dly_bank \
    -Mdir "$BUILD_DIR" \
    -o tb_dly_bank

"./$BUILD_DIR/tb_dly_bank" | tee "$LOG"

if grep -q "Simulation finished: FAIL" "$LOG"; then
    echo "run failed, see $LOG"
    exit 1
fi

if ! grep -q "Simulation finished: PASS" "$LOG"; then
    echo "run ended without a result, see $LOG"
    exit 1
fi

echo "run passed"

// File: test/tb_dly_bank.sv
// Directed testbench for the four-line tap delay bank.
// Drives commands and data on the falling edge and checks the tap readback
// and the delayed data against a tap model and a per-line sample log.
// Built and run by run.sh through list.f.

`timescale 1ns/1ns

`include "dly_consts.svh"

module tb_dly_bank;

    localparam int CLK_PERIOD = 10;
    localparam int RESET_CYC  = 8;
    localparam int DELAY_CYC  = 200;   // data cycles in the delay test
    // cycles per test, summed in run order
    localparam int TEST_CYC   = RESET_CYC + 8 + 44 + 64 + 16 + DELAY_CYC + 8;
    localparam int TIMEOUT_NS = (2 * TEST_CYC + 100) * CLK_PERIOD;

    logic                clk_i_buf;
    logic                reset_buf;
    dly_pkg::line_sel_t  sel_dly;
    logic [1:0]          din_idly;
    logic [1:0]          din_odly;
    dly_pkg::tap_t       g2f_trx_dly_tap;
    logic                dly_ld;
    logic                dly_adj;
    logic                dly_incdec;
    dly_pkg::line_mask_t data_delayed;
    dly_pkg::tap_t       dly_tap_val;

    int          errors;
    int          checks;
    logic [15:0] lfsr_state;
    int          tap_model [`DLY_NUM_LINES];               // expected tap per line
    logic        sample_log [`DLY_NUM_LINES][DELAY_CYC];   // bit fed at each edge

    dly_bank_top uut (
        .clk_i_buf       (clk_i_buf),
        .reset_buf       (reset_buf),
        .sel_dly         (sel_dly),
        .din_idly        (din_idly),
        .din_odly        (din_odly),
        .g2f_trx_dly_tap (g2f_trx_dly_tap),
        .dly_ld          (dly_ld),
        .dly_adj         (dly_adj),
        .dly_incdec      (dly_incdec),
        .data_delayed    (data_delayed),
        .dly_tap_val     (dly_tap_val)
    );

    initial clk_i_buf = 1'b0;
    always #(CLK_PERIOD / 2) clk_i_buf = ~clk_i_buf;

    //****************************************
    // helpers
    //****************************************
    // x^16 + x^14 + x^13 + x^11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], fb};
    endfunction

    task automatic rand_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);   // one step per bit
            v = {v[30:0], lfsr_state[0]};
        end
    endtask

    task automatic compare(input logic [31:0] got, input logic [31:0] exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t ns: %s, got %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    // one rising edge, back at the falling edge
    task automatic tick();
        @(posedge clk_i_buf);
        @(negedge clk_i_buf);
    endtask

    function automatic void step_model(input int line, input logic up);
        if (up && tap_model[line] < `DLY_TAP_MAX)
            tap_model[line]++;
        else if (!up && tap_model[line] > 0)
            tap_model[line]--;
    endfunction

    task automatic load_tap(input int line, input int val);
        sel_dly         = dly_pkg::line_sel_t'(line);
        g2f_trx_dly_tap = dly_pkg::tap_t'(val);
        dly_ld          = 1'b1;
        tick();
        dly_ld          = 1'b0;
        tap_model[line] = val;
    endtask

    // adjust held high for n cycles, one step each
    task automatic adjust_tap(input int line, input logic up, input int n);
        sel_dly    = dly_pkg::line_sel_t'(line);
        dly_incdec = up;
        dly_adj    = 1'b1;
        for (int i = 0; i < n; i++) begin
            tick();
            step_model(line, up);
        end
        dly_adj = 1'b0;
    endtask

    // select lands after one edge, readback register after the next
    task automatic read_tap(input int line, output dly_pkg::tap_t v);
        sel_dly = dly_pkg::line_sel_t'(line);
        dly_ld  = 1'b0;
        dly_adj = 1'b0;
        tick();
        tick();
        v = dly_tap_val;
    endtask

    task automatic check_all_taps(input string ctx);
        dly_pkg::tap_t v;
        for (int i = 0; i < `DLY_NUM_LINES; i++) begin
            read_tap(i, v);
            compare(32'(v), 32'(tap_model[i]), $sformatf("%s, tap of line %0d", ctx, i));
        end
    endtask

    function automatic logic expected_bit(input int line, input int idx);
        if (idx < 0)
            return 1'b0;   // before the feed only zeros went in
        return sample_log[line][idx];
    endfunction

    //****************************************
    // tests
    //****************************************
    task automatic reset_defaults();
        compare(32'(data_delayed), 32'd0, "data_delayed after reset");
        check_all_taps("after reset");
        compare(32'(data_delayed), 32'd0, "data_delayed while idle");
    endtask

    task automatic load_readback();
        logic [31:0]   r;
        dly_pkg::tap_t v;
        for (int line = 0; line < `DLY_NUM_LINES; line++) begin
            rand_bits(6, r);
            load_tap(line, int'(r[5:0]));
            read_tap(line, v);
            compare(32'(v), 32'(tap_model[line]), $sformatf("loaded tap of line %0d", line));
            check_all_taps($sformatf("after load of line %0d", line));
        end
    endtask

    task automatic adjust_saturation();
        logic [31:0]   d;
        logic [31:0]   c;
        dly_pkg::tap_t v;
        load_tap(1, 62);
        adjust_tap(1, 1'b1, 3);
        read_tap(1, v);
        compare(32'(v), 32'(`DLY_TAP_MAX), "increment past top");
        load_tap(2, 1);
        adjust_tap(2, 1'b0, 3);
        read_tap(2, v);
        compare(32'(v), 32'd0, "decrement past zero");
        // random steps on line 3
        load_tap(3, 60);
        for (int k = 0; k < 8; k++) begin
            rand_bits(1, d);
            rand_bits(2, c);
            adjust_tap(3, d[0], int'(c[1:0]) + 1);
            read_tap(3, v);
            compare(32'(v), 32'(tap_model[3]), $sformatf("mixed step %0d on line 3", k));
        end
    endtask

    // load and adjust in the same cycle
    task automatic both_commands(input int line, input int val, input logic up);
        sel_dly         = dly_pkg::line_sel_t'(line);
        g2f_trx_dly_tap = dly_pkg::tap_t'(val);
        dly_incdec      = up;
        dly_ld          = 1'b1;
        dly_adj         = 1'b1;
        tick();
        dly_ld          = 1'b0;
        dly_adj         = 1'b0;
        tap_model[line] = val;   // load wins
    endtask

    task automatic load_priority();
        logic [31:0]   r;
        dly_pkg::tap_t v;
        load_tap(0, 10);
        both_commands(0, 33, 1'b1);
        read_tap(0, v);
        compare(32'(v), 32'd33, "load with increment on line 0");
        rand_bits(6, r);
        both_commands(3, int'(r[5:0]), 1'b0);
        read_tap(3, v);
        compare(32'(v), 32'(tap_model[3]), "load with decrement on line 3");
    endtask

    task automatic delay_per_line();
        logic [31:0] r;
        rand_bits(12, r);
        load_tap(0, 0);
        load_tap(1, `DLY_TAP_MAX);
        load_tap(2, int'(r[5:0]));
        load_tap(3, int'(r[11:6]));
        tick();
        tick();   // taps steady before the feed
        for (int n = 0; n < DELAY_CYC; n++) begin
            rand_bits(4, r);
            for (int i = 0; i < `DLY_NUM_LINES; i++)
                sample_log[i][n] = r[i];
            din_idly = {r[2], r[0]};   // even lines
            din_odly = {r[3], r[1]};   // odd lines
            tick();
            for (int i = 0; i < `DLY_NUM_LINES; i++) begin
                compare(32'(data_delayed[i]), 32'(expected_bit(i, n - 1 - tap_model[i])),
                        $sformatf("line %0d tap %0d cycle %0d", i, tap_model[i], n));
            end
        end
        din_idly = '0;
        din_odly = '0;
    endtask

    //****************************************
    // run
    //****************************************
    initial begin
        errors          = 0;
        checks          = 0;
        lfsr_state      = 16'd15933;
        reset_buf       = 1'b0;
        sel_dly         = '0;
        din_idly        = '0;
        din_odly        = '0;
        g2f_trx_dly_tap = '0;
        dly_ld          = 1'b0;
        dly_adj         = 1'b0;
        dly_incdec      = 1'b0;
        for (int i = 0; i < `DLY_NUM_LINES; i++)
            tap_model[i] = 0;
        repeat (RESET_CYC) tick();
        reset_buf = 1'b1;

        reset_defaults();
        load_readback();
        adjust_saturation();
        load_priority();
        delay_per_line();

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("watchdog timeout: tests still running after %0d ns", TIMEOUT_NS);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule
